// ==== shifter_regs_pkg.sv ====
// shifter register package: register map, shift modes, palette and video address types
`default_nettype none

package shifter_regs_pkg;

	// ------------------------------
	// data types
	// ------------------------------

	// word address into video memory (byte address bits 23:1)
	typedef logic [22:0] vaddr_t;

	// cpu side data and register word address
	typedef logic [15:0] cpu_data_t;
	typedef logic [5:0]  reg_addr_t;

	// shift mode decides the number of bitplanes fetched per 16 pixels
	typedef enum logic [1:0] {
		SHMODE_LOW  = 2'd0,
		SHMODE_MID  = 2'd1,
		SHMODE_MONO = 2'd2
	} shmode_t;

	// palette index and one colour channel, only bits 2:0 are ever stored
	typedef logic [3:0] color_idx_t;
	typedef logic [3:0] color_chan_t;

	// one word of a single bitplane and the plane number
	typedef logic [15:0] plane_word_t;
	typedef logic [1:0]  plane_sel_t;

	// ------------------------------
	// register map (word addresses)
	// ------------------------------
	localparam reg_addr_t REG_BASE_HI       = 6'h00;
	localparam reg_addr_t REG_BASE_MID      = 6'h01;
	localparam reg_addr_t REG_VCNT_HI       = 6'h02;
	localparam reg_addr_t REG_VCNT_MID      = 6'h03;
	localparam reg_addr_t REG_VCNT_LO       = 6'h04;
	localparam reg_addr_t REG_PALETTE_FIRST = 6'h20;
	localparam reg_addr_t REG_PALETTE_LAST  = 6'h2f;
	localparam reg_addr_t REG_SHMODE        = 6'h30;

	// screen at byte address 0x010000, mono after reset
	localparam vaddr_t  RESET_BASE   = 23'h008000;
	localparam shmode_t RESET_SHMODE = SHMODE_MONO;

endpackage

`default_nettype wire

// ==== video_timing_pkg.sv ====
// video timing package: frame geometry, counter type and display state encoding
`default_nettype none

package video_timing_pkg;

	// horizontal and vertical counter
	typedef logic [9:0] pos_t;

	// display states, sync and blank both force the output dark
	typedef enum logic [1:0] {
		ST_SYNC   = 2'd0,
		ST_BLANK  = 2'd1,
		ST_BORDER = 2'd2,
		ST_DISP   = 2'd3
	} disp_state_t;

	// horizontal geometry in clocks, a line is H_END+1 = 96 clocks
	localparam pos_t H_DISPLAY      = 10'd64;
	localparam pos_t H_BORDER_RIGHT = 10'd72;
	localparam pos_t H_BLANK_RIGHT  = 10'd76;
	localparam pos_t H_SYNC         = 10'd84;
	localparam pos_t H_BLANK_LEFT   = 10'd88;
	localparam pos_t H_END          = 10'd95;

	// vertical geometry in lines, a frame is V_END+1 = 16 lines
	localparam pos_t V_DISPLAY    = 10'd8;
	localparam pos_t V_BORDER_BOT = 10'd10;
	localparam pos_t V_BLANK_BOT  = 10'd11;
	localparam pos_t V_SYNC       = 10'd13;
	localparam pos_t V_BLANK_TOP  = 10'd14;
	localparam pos_t V_END        = 10'd15;

	// memory fetch runs one plane word group ahead of the display
	localparam pos_t FETCH_LEAD        = 10'd16;
	localparam int   PLANE_WORD_PIXELS = 16;

endpackage

`default_nettype wire

// ==== cpu_regs.sv ====
// cpu register file: video base, shift mode and palette with byte strobes and read-back
`default_nettype none

module cpu_regs (
	input  wire                           clk,
	input  wire                           cpu_reset,
	input  wire                           cpu_sel,
	input  wire                           cpu_rw,
	input  shifter_regs_pkg::reg_addr_t   cpu_addr,
	input  shifter_regs_pkg::cpu_data_t   cpu_din,
	input  wire                           cpu_uds,
	input  wire                           cpu_lds,
	output shifter_regs_pkg::cpu_data_t   cpu_dout,
	input  shifter_regs_pkg::vaddr_t      vaddr,
	output shifter_regs_pkg::vaddr_t      base_addr,
	output shifter_regs_pkg::shmode_t     shmode,
	input  shifter_regs_pkg::color_idx_t  color_index,
	output shifter_regs_pkg::color_chan_t pal_r,
	output shifter_regs_pkg::color_chan_t pal_g,
	output shifter_regs_pkg::color_chan_t pal_b
);

	// ST palette keeps three bits per channel
	logic [2:0] palette_r [16];
	logic [2:0] palette_g [16];
	logic [2:0] palette_b [16];

	logic wr_en;
	logic pal_hit;

	// strobes are active low
	assign wr_en   = cpu_sel && !cpu_rw;
	assign pal_hit = (cpu_addr >= shifter_regs_pkg::REG_PALETTE_FIRST) &&
		(cpu_addr <= shifter_regs_pkg::REG_PALETTE_LAST);

	// ------------------------------
	// register write
	// ------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			base_addr <= shifter_regs_pkg::RESET_BASE;
			shmode    <= shifter_regs_pkg::RESET_SHMODE;
		end else if (wr_en) begin
			// base hi and mid sit in the low byte
			if (!cpu_lds) begin
				if (cpu_addr == shifter_regs_pkg::REG_BASE_HI)
					base_addr[22:15] <= cpu_din[7:0];
				if (cpu_addr == shifter_regs_pkg::REG_BASE_MID)
					base_addr[14:7] <= cpu_din[7:0];
				// no low byte on the ST, any base write zeroes it
				if (cpu_addr == shifter_regs_pkg::REG_BASE_HI ||
					cpu_addr == shifter_regs_pkg::REG_BASE_MID)
					base_addr[6:0] <= 7'h00;
			end
			// shift mode lives in the high byte
			if (!cpu_uds && cpu_addr == shifter_regs_pkg::REG_SHMODE)
				shmode <= shifter_regs_pkg::shmode_t'(cpu_din[9:8]);
		end
	end

	// palette memory, red in the high byte, green and blue in the low byte
	always_ff @(posedge clk) begin
		if (wr_en && pal_hit) begin
			if (!cpu_uds)
				palette_r[cpu_addr[3:0]] <= cpu_din[10:8];
			if (!cpu_lds) begin
				palette_g[cpu_addr[3:0]] <= cpu_din[6:4];
				palette_b[cpu_addr[3:0]] <= cpu_din[2:0];
			end
		end
	end

	// ------------------------------
	// register read
	// ------------------------------
	always_comb begin
		cpu_dout = '0;
		if (cpu_sel && cpu_rw) begin
			case (cpu_addr)
				shifter_regs_pkg::REG_BASE_HI:  cpu_dout = {8'h00, base_addr[22:15]};
				shifter_regs_pkg::REG_BASE_MID: cpu_dout = {8'h00, base_addr[14:7]};
				// live address counter, read only
				shifter_regs_pkg::REG_VCNT_HI:  cpu_dout = {8'h00, vaddr[22:15]};
				shifter_regs_pkg::REG_VCNT_MID: cpu_dout = {8'h00, vaddr[14:7]};
				shifter_regs_pkg::REG_VCNT_LO:  cpu_dout = {8'h00, vaddr[6:0], 1'b0};
				shifter_regs_pkg::REG_SHMODE:   cpu_dout = {6'h00, shmode, 8'h00};
				default: begin
					// unused bit 3 of each nibble reads as zero
					if (pal_hit)
						cpu_dout = {5'h00, palette_r[cpu_addr[3:0]], 1'b0,
							palette_g[cpu_addr[3:0]], 1'b0, palette_b[cpu_addr[3:0]]};
				end
			endcase
		end
	end

	// second port for the pixel path
	assign pal_r = {1'b0, palette_r[color_index]};
	assign pal_g = {1'b0, palette_g[color_index]};
	assign pal_b = {1'b0, palette_b[color_index]};

endmodule

`default_nettype wire

// ==== video_timing.sv ====
// video timing generator: line and frame counters, display states, syncs and fetch window
`default_nettype none

module video_timing (
	input  wire                   clk,
	input  wire                   cpu_reset,
	output video_timing_pkg::pos_t hcnt,
	output logic                  fetch_en,
	output logic                  frame_reload,
	output logic                  blank,
	output logic                  border,
	output logic                  hs,
	output logic                  vs
);

	video_timing_pkg::pos_t        vcnt;
	video_timing_pkg::disp_state_t h_state;
	video_timing_pkg::disp_state_t v_state;

	// next line is a display line, sampled once per line ahead of the fetch window
	logic fetch_v;

	// ------------------------------
	// horizontal
	// ------------------------------
	// states change one clock early so they line up with hcnt
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			hcnt    <= '0;
			h_state <= video_timing_pkg::ST_DISP;
		end else begin
			hcnt <= (hcnt == video_timing_pkg::H_END) ? '0 : hcnt + 10'd1;
			case (h_state)
				video_timing_pkg::ST_DISP:
					if (hcnt == video_timing_pkg::H_DISPLAY - 10'd1)
						h_state <= video_timing_pkg::ST_BORDER;
				video_timing_pkg::ST_BORDER:
					if (hcnt == video_timing_pkg::H_BORDER_RIGHT - 10'd1)
						h_state <= video_timing_pkg::ST_BLANK;
				// blank occurs twice per line, around the sync pulse
				video_timing_pkg::ST_BLANK:
					if (hcnt == video_timing_pkg::H_SYNC - 10'd1)
						h_state <= video_timing_pkg::ST_SYNC;
					else if (hcnt == video_timing_pkg::H_END)
						h_state <= video_timing_pkg::ST_DISP;
				default:
					if (hcnt == video_timing_pkg::H_BLANK_LEFT - 10'd1)
						h_state <= video_timing_pkg::ST_BLANK;
			endcase
		end
	end

	// ------------------------------
	// vertical, steps at hsync start
	// ------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			vcnt    <= '0;
			v_state <= video_timing_pkg::ST_DISP;
		end else if (hcnt == video_timing_pkg::H_SYNC) begin
			vcnt <= (vcnt == video_timing_pkg::V_END) ? '0 : vcnt + 10'd1;
			case (v_state)
				video_timing_pkg::ST_DISP:
					if (vcnt == video_timing_pkg::V_DISPLAY - 10'd1)
						v_state <= video_timing_pkg::ST_BORDER;
				video_timing_pkg::ST_BORDER:
					if (vcnt == video_timing_pkg::V_BORDER_BOT - 10'd1)
						v_state <= video_timing_pkg::ST_BLANK;
				video_timing_pkg::ST_BLANK:
					if (vcnt == video_timing_pkg::V_SYNC - 10'd1)
						v_state <= video_timing_pkg::ST_SYNC;
					else if (vcnt == video_timing_pkg::V_END)
						v_state <= video_timing_pkg::ST_DISP;
				default:
					if (vcnt == video_timing_pkg::V_BLANK_TOP - 10'd1)
						v_state <= video_timing_pkg::ST_BLANK;
			endcase
		end
	end

	// vcnt still holds the previous line when the window opens at hcnt 80
	always_ff @(posedge clk) begin
		if (cpu_reset)
			fetch_v <= 1'b0;
		else if (hcnt == video_timing_pkg::H_END - video_timing_pkg::FETCH_LEAD)
			fetch_v <= (vcnt == video_timing_pkg::V_END) ||
				(vcnt < video_timing_pkg::V_DISPLAY - 10'd1);
	end

	// window wraps: tail of previous line plus the first 48 clocks
	assign fetch_en = fetch_v &&
		((hcnt > video_timing_pkg::H_END - video_timing_pkg::FETCH_LEAD) ||
		(hcnt < video_timing_pkg::H_DISPLAY - video_timing_pkg::FETCH_LEAD));

	// reload the address counter once per frame, well clear of the display
	assign frame_reload = (hcnt == video_timing_pkg::H_END) &&
		(vcnt == video_timing_pkg::V_BLANK_BOT);

	assign blank = (h_state == video_timing_pkg::ST_SYNC) ||
		(h_state == video_timing_pkg::ST_BLANK) ||
		(v_state == video_timing_pkg::ST_SYNC) ||
		(v_state == video_timing_pkg::ST_BLANK);
	assign border = (h_state == video_timing_pkg::ST_BORDER) ||
		(v_state == video_timing_pkg::ST_BORDER);

	// active low syncs
	assign hs = (h_state != video_timing_pkg::ST_SYNC);
	assign vs = (v_state != video_timing_pkg::ST_SYNC);

endmodule

`default_nettype wire

// ==== video_fetch.sv ====
// video fetch engine: address counter, plane sequencing, read strobe and plane latches
`default_nettype none

module video_fetch (
	input  wire                           clk,
	input  wire                           cpu_reset,
	input  shifter_regs_pkg::shmode_t     shmode,
	input  shifter_regs_pkg::vaddr_t      base_addr,
	input  video_timing_pkg::pos_t        hcnt,
	input  wire                           fetch_en,
	input  wire                           frame_reload,
	input  shifter_regs_pkg::plane_word_t data,
	output logic                          read,
	output shifter_regs_pkg::vaddr_t      vaddr,
	output shifter_regs_pkg::plane_word_t plane_data0,
	output shifter_regs_pkg::plane_word_t plane_data1,
	output shifter_regs_pkg::plane_word_t plane_data2,
	output shifter_regs_pkg::plane_word_t plane_data3
);

	logic [2:0]                     nplanes;
	shifter_regs_pkg::plane_sel_t   plane;
	shifter_regs_pkg::plane_word_t  plane_latch [4];

	// planes per 16 pixel group
	always_comb begin
		case (shmode)
			shifter_regs_pkg::SHMODE_LOW: nplanes = 3'd4;
			shifter_regs_pkg::SHMODE_MID: nplanes = 3'd2;
			default:                      nplanes = 3'd1;
		endcase
	end

	// one read every fourth clock, group slot hcnt[3:2] selects the plane
	assign read = fetch_en && (hcnt[1:0] == 2'b00) && ({1'b0, hcnt[3:2]} < nplanes);

	// address and plane counter
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			vaddr <= shifter_regs_pkg::RESET_BASE;
			plane <= '0;
		end else if (frame_reload) begin
			vaddr <= base_addr;
			plane <= '0;
		end else if (read) begin
			vaddr <= vaddr + 23'd1;
			if (plane == shifter_regs_pkg::plane_sel_t'(nplanes - 3'd1))
				plane <= '0;
			else
				plane <= plane + 2'd1;
		end
	end

	// memory answers in the read cycle, the word is taken at its closing edge
	always_ff @(posedge clk) begin
		if (read) begin
			plane_latch[plane] <= data;
			// planes outside the mode must feed zero into the index
			if (nplanes < 3'd4) begin
				plane_latch[2] <= '0;
				plane_latch[3] <= '0;
			end
			if (nplanes < 3'd2)
				plane_latch[1] <= '0;
		end
	end

	assign plane_data0 = plane_latch[0];
	assign plane_data1 = plane_latch[1];
	assign plane_data2 = plane_latch[2];
	assign plane_data3 = plane_latch[3];

endmodule

`default_nettype wire

// ==== pixel_shifter.sv ====
// pixel output stage: bitplane shift registers, palette or mono pixel, blanking register
`default_nettype none

module pixel_shifter (
	input  wire                           clk,
	input  wire                           cpu_reset,
	input  shifter_regs_pkg::shmode_t     shmode,
	input  video_timing_pkg::pos_t        hcnt,
	input  wire                           blank,
	input  wire                           border,
	input  shifter_regs_pkg::plane_word_t plane_data0,
	input  shifter_regs_pkg::plane_word_t plane_data1,
	input  shifter_regs_pkg::plane_word_t plane_data2,
	input  shifter_regs_pkg::plane_word_t plane_data3,
	output shifter_regs_pkg::color_idx_t  color_index,
	input  shifter_regs_pkg::color_chan_t pal_r,
	input  shifter_regs_pkg::color_chan_t pal_g,
	input  shifter_regs_pkg::color_chan_t pal_b,
	output shifter_regs_pkg::color_chan_t video_r,
	output shifter_regs_pkg::color_chan_t video_g,
	output shifter_regs_pkg::color_chan_t video_b
);

	shifter_regs_pkg::plane_word_t shift_reg [4];
	logic                          mono;
	logic                          mono_bit;

	// reload on the last pixel of a group, msb is the current pixel
	always_ff @(posedge clk) begin
		if (hcnt[3:0] == 4'(video_timing_pkg::PLANE_WORD_PIXELS - 1)) begin
			shift_reg[0] <= plane_data0;
			shift_reg[1] <= plane_data1;
			shift_reg[2] <= plane_data2;
			shift_reg[3] <= plane_data3;
		end else begin
			for (int i = 0; i < 4; i++)
				shift_reg[i] <= {shift_reg[i][14:0], 1'b0};
		end
	end

	assign mono = (shmode == shifter_regs_pkg::SHMODE_MONO);

	// mono looks up entry 0 to get the inversion bit from its blue
	assign color_index = (border || mono) ? '0 :
		{shift_reg[3][15], shift_reg[2][15], shift_reg[1][15], shift_reg[0][15]};

	// border shows as background in mono as well
	assign mono_bit = (shift_reg[0][15] && !border) ^ pal_b[0];

	// output register, one clock behind hcnt
	always_ff @(posedge clk) begin
		if (cpu_reset || blank) begin
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
		end else if (mono) begin
			video_r <= {4{mono_bit}};
			video_g <= {4{mono_bit}};
			video_b <= {4{mono_bit}};
		end else begin
			video_r <= pal_r;
			video_g <= pal_g;
			video_b <= pal_b;
		end
	end

endmodule

`default_nettype wire

// ==== atari_shifter.sv ====
// atari st video shifter top: register file, timing, fetch engine and pixel output
`default_nettype none

module atari_shifter (
	input  wire                           clk,
	input  wire                           cpu_reset,
	// cpu register port
	input  wire                           cpu_sel,
	input  wire                           cpu_rw,
	input  shifter_regs_pkg::reg_addr_t   cpu_addr,
	input  shifter_regs_pkg::cpu_data_t   cpu_din,
	input  wire                           cpu_uds,
	input  wire                           cpu_lds,
	output shifter_regs_pkg::cpu_data_t   cpu_dout,
	// video memory port
	output logic                          read,
	output shifter_regs_pkg::vaddr_t      vaddr,
	input  shifter_regs_pkg::plane_word_t data,
	// screen
	output logic                          hs,
	output logic                          vs,
	output shifter_regs_pkg::color_chan_t video_r,
	output shifter_regs_pkg::color_chan_t video_g,
	output shifter_regs_pkg::color_chan_t video_b
);

	shifter_regs_pkg::vaddr_t      base_addr;
	shifter_regs_pkg::shmode_t     shmode;
	shifter_regs_pkg::color_idx_t  color_index;
	shifter_regs_pkg::color_chan_t pal_r;
	shifter_regs_pkg::color_chan_t pal_g;
	shifter_regs_pkg::color_chan_t pal_b;
	video_timing_pkg::pos_t        hcnt;
	logic                          fetch_en;
	logic                          frame_reload;
	logic                          blank;
	logic                          border;
	shifter_regs_pkg::plane_word_t plane_data0;
	shifter_regs_pkg::plane_word_t plane_data1;
	shifter_regs_pkg::plane_word_t plane_data2;
	shifter_regs_pkg::plane_word_t plane_data3;

	cpu_regs regs0 (
		.clk(clk), .cpu_reset(cpu_reset),
		.cpu_sel(cpu_sel), .cpu_rw(cpu_rw), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
		.cpu_uds(cpu_uds), .cpu_lds(cpu_lds), .cpu_dout(cpu_dout),
		.vaddr(vaddr), .base_addr(base_addr), .shmode(shmode),
		.color_index(color_index), .pal_r(pal_r), .pal_g(pal_g), .pal_b(pal_b)
	);

	video_timing timing0 (
		.clk(clk), .cpu_reset(cpu_reset), .hcnt(hcnt), .fetch_en(fetch_en),
		.frame_reload(frame_reload), .blank(blank), .border(border), .hs(hs), .vs(vs)
	);

	video_fetch fetch0 (
		.clk(clk), .cpu_reset(cpu_reset), .shmode(shmode), .base_addr(base_addr),
		.hcnt(hcnt), .fetch_en(fetch_en), .frame_reload(frame_reload),
		.data(data), .read(read), .vaddr(vaddr),
		.plane_data0(plane_data0), .plane_data1(plane_data1),
		.plane_data2(plane_data2), .plane_data3(plane_data3)
	);

	pixel_shifter shift0 (
		.clk(clk), .cpu_reset(cpu_reset), .shmode(shmode), .hcnt(hcnt),
		.blank(blank), .border(border),
		.plane_data0(plane_data0), .plane_data1(plane_data1),
		.plane_data2(plane_data2), .plane_data3(plane_data3),
		.color_index(color_index), .pal_r(pal_r), .pal_g(pal_g), .pal_b(pal_b),
		.video_r(video_r), .video_g(video_g), .video_b(video_b)
	);

endmodule

`default_nettype wire

// ==== shifter_assertions.sv ====
// fetch engine checks: read inside the fetch window, address stepping, quiet after reset
`default_nettype none

module shifter_assertions (
	input wire                      clk,
	input wire                      cpu_reset,
	input wire                      read,
	input wire                      fetch_en,
	input wire                      frame_reload,
	input video_timing_pkg::pos_t   hcnt,
	input shifter_regs_pkg::vaddr_t vaddr
);
	timeunit 1ns;
	timeprecision 1ps;

	// no memory cycle outside the window, which wraps from hcnt 80 to 47
	read_in_window: assert property (@(posedge clk) disable iff (cpu_reset)
		read |-> fetch_en &&
		((hcnt >= video_timing_pkg::H_END + 10'd1 - video_timing_pkg::FETCH_LEAD) ||
		(hcnt < video_timing_pkg::H_DISPLAY - video_timing_pkg::FETCH_LEAD)))
		else $error("read strobe outside the fetch window");

	// address counter steps once per word
	addr_step: assert property (@(posedge clk) disable iff (cpu_reset)
		(read && !frame_reload) |=> (vaddr == $past(vaddr) + 23'd1))
		else $error("video address did not advance after a read");

	reset_quiet: assert property (@(posedge clk) cpu_reset |=> !read)
		else $error("read strobe high right after reset");

endmodule

bind video_fetch shifter_assertions chk0 (
	.clk(clk), .cpu_reset(cpu_reset), .read(read), .fetch_en(fetch_en),
	.frame_reload(frame_reload), .hcnt(hcnt), .vaddr(vaddr)
);

`default_nettype wire

// ==== tb_atari_shifter.sv ====
// testbench for the st video shifter: register checks, fetch, sync and pixel counts per frame
`default_nettype none

module tb_atari_shifter;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		shifter_regs_pkg::shmode_t     mode;
		shifter_regs_pkg::cpu_data_t   pal0;
		shifter_regs_pkg::cpu_data_t   pal1;
		shifter_regs_pkg::plane_word_t pattern;
		shifter_regs_pkg::color_chan_t exp_r;
		shifter_regs_pkg::color_chan_t exp_g;
		shifter_regs_pkg::color_chan_t exp_b;
	} row_t;

	localparam int NROWS = 4;
	localparam int FRAME_CLKS = 1536;
	localparam int LIMIT_NS = NROWS * 3 * FRAME_CLKS * 40 + 6 * FRAME_CLKS * 40;

	logic clk, cpu_reset, cpu_sel, cpu_rw, cpu_uds, cpu_lds, read, hs, vs;
	shifter_regs_pkg::reg_addr_t cpu_addr;
	shifter_regs_pkg::cpu_data_t cpu_din, cpu_dout, rd_val, wr_val;
	shifter_regs_pkg::vaddr_t vaddr, exp_addr, base_exp;
	shifter_regs_pkg::plane_word_t data, cur_pattern;
	shifter_regs_pkg::color_chan_t video_r, video_g, video_b;
	shifter_regs_pkg::color_chan_t cur_r, cur_g, cur_b, bord_r, bord_g, bord_b;
	shifter_regs_pkg::shmode_t cur_mode;
	row_t rows [NROWS];
	int seed, rd_count, err_data, err_addr, err_chan, err_other;
	int frame_no, target, reads, match, hs_pulses, vs_low, hs_run, exp_match;
	int snap_reads, snap_match, snap_hs, snap_vs;
	logic mon_on, addr_on, hs_q, vs_q;

	atari_shifter dut0 (
		.clk(clk), .cpu_reset(cpu_reset), .cpu_sel(cpu_sel), .cpu_rw(cpu_rw),
		.cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_uds(cpu_uds), .cpu_lds(cpu_lds),
		.cpu_dout(cpu_dout), .read(read), .vaddr(vaddr), .data(data),
		.hs(hs), .vs(vs), .video_r(video_r), .video_g(video_g), .video_b(video_b)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_data(input string name, input shifter_regs_pkg::cpu_data_t got,
		input shifter_regs_pkg::cpu_data_t exp);
		if (got !== exp) begin
			err_data++;
			$display("ERROR %s got 0x%h exp 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input shifter_regs_pkg::vaddr_t got,
		input shifter_regs_pkg::vaddr_t exp);
		if (got !== exp) begin
			err_addr++;
			$display("ERROR %s got 0x%h exp 0x%h", name, got, exp);
		end
	endtask

	task automatic check_chan(input string name, input shifter_regs_pkg::color_chan_t got,
		input shifter_regs_pkg::color_chan_t exp);
		if (got !== exp) begin
			err_chan++;
			$display("ERROR %s got 0x%h exp 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			err_other++;
			$display("frame had %0d %s where %0d were expected", got, what, exp);
		end
	endtask

	// ------------------------------
	// cpu bus and memory model
	// ------------------------------
	task automatic cpu_write_strobed(input shifter_regs_pkg::reg_addr_t a,
		input shifter_regs_pkg::cpu_data_t d, input logic uds, input logic lds);
		@(posedge clk);
		#2;
		cpu_sel = 1'b1;
		cpu_rw = 1'b0;
		cpu_addr = a;
		cpu_din = d;
		cpu_uds = uds;
		cpu_lds = lds;
		@(posedge clk);
		#2;
		cpu_sel = 1'b0;
		cpu_rw = 1'b1;
		cpu_uds = 1'b1;
		cpu_lds = 1'b1;
	endtask

	// word write, both strobes low
	task automatic cpu_write(input shifter_regs_pkg::reg_addr_t a,
		input shifter_regs_pkg::cpu_data_t d);
		cpu_write_strobed(a, d, 1'b0, 1'b0);
	endtask

	task automatic cpu_read(input shifter_regs_pkg::reg_addr_t a,
		output shifter_regs_pkg::cpu_data_t d);
		@(posedge clk);
		#2;
		cpu_sel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = a;
		@(negedge clk);
		d = cpu_dout;
		@(posedge clk);
		#2;
		cpu_sel = 1'b0;
	endtask

	function automatic int planes_for(input shifter_regs_pkg::shmode_t m);
		return (m == shifter_regs_pkg::SHMODE_LOW) ? 4 :
			(m == shifter_regs_pkg::SHMODE_MID) ? 2 : 1;
	endfunction

	// reads since the last reload, vs low lies between reload and the next fetch
	always @(posedge clk) begin
		if (cpu_reset || !vs)
			rd_count <= 0;
		else if (read)
			rd_count <= rd_count + 1;
	end

	// only plane 0 carries the pattern, so pixel index is 0 or 1
	always @(posedge clk) begin
		#2;
		data = ((rd_count % planes_for(cur_mode)) == 0) ? cur_pattern : 16'h0000;
	end

	// ------------------------------
	// monitor, frame runs from one vs fall to the next
	// ------------------------------
	always @(negedge clk) begin
		if (vs_q && !vs) begin
			snap_reads = reads;
			snap_match = match;
			snap_hs = hs_pulses;
			snap_vs = vs_low;
			reads = 0;
			match = 0;
			hs_pulses = 0;
			vs_low = 0;
			frame_no++;
			exp_addr = base_exp;
			addr_on = mon_on;
		end
		if (read) begin
			reads++;
			if (addr_on)
				check_addr("vaddr", vaddr, exp_addr);
			exp_addr = exp_addr + 23'd1;
		end
		if (!hs || !vs) begin
			check_chan("video_r", video_r, 4'h0);
			check_chan("video_g", video_g, 4'h0);
			check_chan("video_b", video_b, 4'h0);
		end
		if (video_r == cur_r && video_g == cur_g && video_b == cur_b)
			match++;
		if (!vs)
			vs_low++;
		if (hs_q && !hs) begin
			hs_pulses++;
			hs_run = 0;
		end
		if (!hs)
			hs_run++;
		if (!hs_q && hs && hs_run != 4 && mon_on) begin
			err_other++;
			$display("hs pulse lasted %0d clocks instead of 4", hs_run);
		end
		hs_q = hs;
		vs_q = vs;
	end

	initial begin
		#(LIMIT_NS);
		$display("watchdog expired before all rows were run");
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		seed = 45;
		cpu_reset = 1'b1;
		cpu_sel = 1'b0;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_din = '0;
		cpu_uds = 1'b1;
		cpu_lds = 1'b1;
		data = '0;
		{err_data, err_addr, err_chan, err_other, frame_no} = '0;
		{reads, match, hs_pulses, vs_low, hs_run} = '0;
		{mon_on, addr_on, hs_q, vs_q} = 4'b0011;
		cur_mode = shifter_regs_pkg::SHMODE_MONO;
		cur_pattern = '0;
		cur_r = '0;
		cur_g = '0;
		cur_b = '0;
		base_exp = {8'h01, 8'h23, 7'h00};
		exp_addr = base_exp;
		// mode, palette 0, palette 1, plane 0 word, r g b of display pixels
		rows[0] = {shifter_regs_pkg::SHMODE_LOW, 16'h0000, 16'h0700, 16'hffff,
			4'h7, 4'h0, 4'h0};
		rows[1] = {shifter_regs_pkg::SHMODE_MID, 16'h0300, 16'h0452, 16'hffff,
			4'h4, 4'h5, 4'h2};
		rows[2] = {shifter_regs_pkg::SHMODE_MONO, 16'h0000, 16'h0777, 16'hffff,
			4'hf, 4'hf, 4'hf};
		rows[3] = {shifter_regs_pkg::SHMODE_MONO, 16'h0001, 16'h0777, 16'hffff,
			4'h0, 4'h0, 4'h0};
		repeat (5) @(posedge clk);
		#2;
		cpu_reset = 1'b0;

		// register read-back
		cpu_write(shifter_regs_pkg::REG_BASE_HI, 16'hff01);
		cpu_write(shifter_regs_pkg::REG_BASE_MID, 16'hff23);
		cpu_read(shifter_regs_pkg::REG_BASE_HI, rd_val);
		check_data("cpu_dout base_hi", rd_val, 16'h0001);
		cpu_read(shifter_regs_pkg::REG_BASE_MID, rd_val);
		check_data("cpu_dout base_mid", rd_val, 16'h0023);
		cpu_write(shifter_regs_pkg::REG_SHMODE, 16'h0100);
		cpu_read(shifter_regs_pkg::REG_SHMODE, rd_val);
		check_data("cpu_dout shmode", rd_val, 16'h0100);
		for (int i = 2; i < 16; i++) begin
			wr_val = 16'($random(seed));
			cpu_write(6'(32 + i), wr_val);
			cpu_read(6'(32 + i), rd_val);
			check_data("cpu_dout palette", rd_val, wr_val & 16'h0777);
		end

		// upper strobe alone reaches red only, lower alone green and blue
		cpu_write(6'h22, 16'h0000);
		cpu_write_strobed(6'h22, 16'h0777, 1'b0, 1'b1);
		cpu_read(6'h22, rd_val);
		check_data("cpu_dout palette uds", rd_val, 16'h0700);
		cpu_write_strobed(6'h22, 16'h0555, 1'b1, 1'b0);
		cpu_read(6'h22, rd_val);
		check_data("cpu_dout palette lds", rd_val, 16'h0755);
		mon_on = 1'b1;

		for (int r = 0; r < NROWS; r++) begin
			cpu_write(shifter_regs_pkg::REG_SHMODE, {6'h00, rows[r].mode, 8'h00});
			cpu_write(shifter_regs_pkg::REG_PALETTE_FIRST, rows[r].pal0);
			cpu_write(6'h21, rows[r].pal1);
			cur_mode = rows[r].mode;
			cur_pattern = rows[r].pattern;
			cur_r = rows[r].exp_r;
			cur_g = rows[r].exp_g;
			cur_b = rows[r].exp_b;
			// mono border is the inverse of a set pixel, colour border is entry 0
			if (cur_mode == shifter_regs_pkg::SHMODE_MONO) begin
				bord_r = ~cur_r;
				bord_g = ~cur_g;
				bord_b = ~cur_b;
			end else begin
				bord_r = {1'b0, rows[r].pal0[10:8]};
				bord_g = {1'b0, rows[r].pal0[6:4]};
				bord_b = {1'b0, rows[r].pal0[2:0]};
			end
			// 512 display pixels, 208 border pixels, 816 blank clocks per frame
			exp_match = 512;
			if (bord_r == cur_r && bord_g == cur_g && bord_b == cur_b)
				exp_match += 208;
			if (cur_r == 0 && cur_g == 0 && cur_b == 0)
				exp_match += 816;
			target = frame_no + 3;
			wait (frame_no == target);
			check_count("reads", snap_reads, 32 * planes_for(cur_mode));
			check_count("hs pulses", snap_hs, 16);
			check_count("vs low clocks", snap_vs, 96);
			check_count("clocks with expected colour", snap_match, exp_match);
		end

		$display("errors: data %0d addr %0d chan %0d other %0d",
			err_data, err_addr, err_chan, err_other);
		if (err_data + err_addr + err_chan + err_other == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
shifter_regs_pkg.sv
video_timing_pkg.sv
cpu_regs.sv
video_timing.sv
video_fetch.sv
pixel_shifter.sv
atari_shifter.sv
shifter_assertions.sv
tb_atari_shifter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the shifter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_atari_shifter -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
exit 1
